//--- include/menu_consts.svh
`ifndef MENU_CONSTS_SVH
`define MENU_CONSTS_SVH

// Visible area of the 800x600 mode.
`define MENU_H_ACTIVE     11'd800
`define MENU_V_ACTIVE     11'd600

// Label bars. Bar i starts at MENU_BAR_Y0 + i * MENU_BAR_PITCH.
`define MENU_BAR_X        11'd300
`define MENU_BAR_W        11'd240
`define MENU_BAR_H        11'd40
`define MENU_BAR_Y0       11'd200
`define MENU_BAR_PITCH    11'd80

// The pointer square shares its top edge with the selected bar.
`define MENU_PTR_X        11'd260
`define MENU_PTR_SIZE     11'd24

`define MENU_BAR_RGB      12'hFFF
`define MENU_PTR_RGB      12'hF00
`define MENU_BG_BLUE      4'd4

`define MENU_MAIN_ITEMS   2'd3

`define MENU_PAGE_MAIN    2'd0
`define MENU_PAGE_OPTIONS 2'd1
`define MENU_PAGE_CREDITS 2'd2
`define MENU_PAGE_PLAYING 2'd3

`define MENU_KEY_UP       0
`define MENU_KEY_DOWN     1
`define MENU_KEY_ENTER    2

`endif

//--- verilog/menu_pkg.sv
package menu_pkg;

    // One 12-bit colour, four bits per channel.
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_s;

    // The same pixel word, seen either as channels or as a raw value.
    typedef union packed {
        logic [11:0] raw;
        pixel_s      ch;
    } pixel_u;

endpackage

//--- verilog/vga_stream_if.sv
interface vga_stream_if;
    import menu_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    pixel_u      rgb;

    // The producing stage registers every field each clock.
    modport src (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport dst (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

//--- verilog/menu_background.sv
`include "menu_consts.svh"

module menu_background (
    input  logic        clk,
    input  logic        reset,
    input  logic [10:0] hcount,
    input  logic [10:0] vcount,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        hblnk,
    input  logic        vblnk,
    vga_stream_if.src   stage
);
    import menu_pkg::*;

    pixel_u grad;
    logic   on_screen;

    assign on_screen = !hblnk && !vblnk &&
                       (hcount < `MENU_H_ACTIVE) && (vcount < `MENU_V_ACTIVE);

    // Red follows the column, green the row, blue is flat.
    always_comb begin
        grad.raw = '0;
        if (on_screen) begin
            grad.ch.r = hcount[9:6];
            grad.ch.g = vcount[9:6];
            grad.ch.b = `MENU_BG_BLUE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage.hsync <= 1'b0;
            stage.vsync <= 1'b0;
            stage.hblnk <= 1'b0;
            stage.vblnk <= 1'b0;
            stage.rgb   <= '0;
        end else begin
            stage.hsync <= hsync;
            stage.vsync <= vsync;
            stage.hblnk <= hblnk;
            stage.vblnk <= vblnk;
            stage.rgb   <= grad;
        end
    end

    always_ff @(posedge clk) begin
        stage.hcount <= hcount;
        stage.vcount <= vcount;
    end

endmodule

//--- verilog/menu_page_fsm.sv
`include "menu_consts.svh"

module menu_page_fsm (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] keyboard,
    input  logic       back_to_main_menu_flag,
    output logic [1:0] page,
    output logic [1:0] item,
    output logic       start_game_flag
);

    logic [1:0] page_nxt;
    logic [1:0] item_nxt;

    always_comb begin
        page_nxt = page;
        item_nxt = item;
        case (page)
            `MENU_PAGE_MAIN: begin
                if (keyboard[`MENU_KEY_ENTER]) begin
                    item_nxt = 2'd0;
                    case (item)
                        2'd0:    page_nxt = `MENU_PAGE_PLAYING;
                        2'd1:    page_nxt = `MENU_PAGE_OPTIONS;
                        default: page_nxt = `MENU_PAGE_CREDITS;
                    endcase
                end else if (keyboard[`MENU_KEY_UP]) begin
                    if (item != 2'd0)
                        item_nxt = item - 2'd1; // Stops at the first item.
                end else if (keyboard[`MENU_KEY_DOWN]) begin
                    if (item < `MENU_MAIN_ITEMS - 2'd1)
                        item_nxt = item + 2'd1;
                end
            end
            // The game owns the keys until it hands control back.
            `MENU_PAGE_PLAYING: begin
                if (back_to_main_menu_flag) begin
                    page_nxt = `MENU_PAGE_MAIN;
                    item_nxt = 2'd0;
                end
            end
            default: begin
                item_nxt = 2'd0; // Sub-pages only have the back item.
                if (keyboard[`MENU_KEY_ENTER])
                    page_nxt = `MENU_PAGE_MAIN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            page            <= `MENU_PAGE_MAIN;
            item            <= 2'd0;
            start_game_flag <= 1'b0;
        end else begin
            page            <= page_nxt;
            item            <= item_nxt;
            start_game_flag <= (page == `MENU_PAGE_PLAYING); // One clock behind the page.
        end
    end

endmodule

//--- verilog/menu_labels.sv
`include "menu_consts.svh"

module menu_labels (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] page,
    vga_stream_if.dst  upstream,
    vga_stream_if.src  downstream
);

    logic [1:0]  n_bars;
    logic [10:0] bar_y;
    logic        in_bar;

    always_comb begin
        case (page)
            `MENU_PAGE_MAIN:    n_bars = `MENU_MAIN_ITEMS;
            `MENU_PAGE_PLAYING: n_bars = 2'd0;
            default:            n_bars = 2'd1;
        endcase
        in_bar = 1'b0;
        bar_y  = `MENU_BAR_Y0;
        for (int i = 0; i < `MENU_MAIN_ITEMS; i++) begin
            bar_y = `MENU_BAR_Y0 + `MENU_BAR_PITCH * 11'(i);
            if (i < n_bars &&
                upstream.hcount >= `MENU_BAR_X &&
                upstream.hcount <  `MENU_BAR_X + `MENU_BAR_W &&
                upstream.vcount >= bar_y &&
                upstream.vcount <  bar_y + `MENU_BAR_H)
                in_bar = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            downstream.hsync <= 1'b0;
            downstream.vsync <= 1'b0;
            downstream.hblnk <= 1'b0;
            downstream.vblnk <= 1'b0;
            downstream.rgb   <= '0;
        end else begin
            downstream.hsync <= upstream.hsync;
            downstream.vsync <= upstream.vsync;
            downstream.hblnk <= upstream.hblnk;
            downstream.vblnk <= upstream.vblnk;
            if (in_bar)
                downstream.rgb.raw <= `MENU_BAR_RGB;
            else
                downstream.rgb <= upstream.rgb;
        end
    end

    always_ff @(posedge clk) begin
        downstream.hcount <= upstream.hcount;
        downstream.vcount <= upstream.vcount;
    end

endmodule

//--- verilog/menu_pointer.sv
`include "menu_consts.svh"

module menu_pointer (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  page,
    input  logic [1:0]  item,
    vga_stream_if.dst   upstream,
    output logic        hsync,
    output logic        vsync,
    output logic [11:0] rgb
);

    logic [10:0] ptr_y;
    logic        ptr_on;
    logic        in_ptr;

    // The pointer position lags the menu state by this one register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_y  <= `MENU_BAR_Y0;
            ptr_on <= 1'b0;
        end else begin
            ptr_y  <= `MENU_BAR_Y0 + `MENU_BAR_PITCH * 11'(item);
            ptr_on <= (page != `MENU_PAGE_PLAYING);
        end
    end

    assign in_ptr = ptr_on && !upstream.hblnk && !upstream.vblnk &&
                    upstream.hcount >= `MENU_PTR_X &&
                    upstream.hcount <  `MENU_PTR_X + `MENU_PTR_SIZE &&
                    upstream.vcount >= ptr_y &&
                    upstream.vcount <  ptr_y + `MENU_PTR_SIZE;

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            rgb   <= 12'h000;
        end else begin
            hsync <= upstream.hsync;
            vsync <= upstream.vsync;
            rgb   <= in_ptr ? `MENU_PTR_RGB : upstream.rgb.raw; // Pointer drawn on top.
        end
    end

endmodule

//--- verilog/game_menu.sv
module game_menu (
    input  logic        clk,
    input  logic        reset,
    input  logic [10:0] hcount,
    input  logic [10:0] vcount,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        hblnk,
    input  logic        vblnk,
    input  logic [2:0]  keyboard,
    input  logic        back_to_main_menu_flag,
    output logic        hsync_out,
    output logic        vsync_out,
    output logic [11:0] rgb_out,
    output logic        start_game_flag
);

    logic [1:0] page;
    logic [1:0] item;

    vga_stream_if stage1 ();
    vga_stream_if stage2 ();

    // Three registered stages, so the picture trails the input timing by 3 clocks.
    menu_background menu_background (
        .clk    (clk),
        .reset  (reset),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .stage  (stage1.src)
    );

    menu_page_fsm menu_page_fsm (
        .clk                    (clk),
        .reset                  (reset),
        .keyboard               (keyboard),
        .back_to_main_menu_flag (back_to_main_menu_flag),
        .page                   (page),
        .item                   (item),
        .start_game_flag        (start_game_flag)
    );

    menu_labels menu_labels (
        .clk        (clk),
        .reset      (reset),
        .page       (page),
        .upstream   (stage1.dst),
        .downstream (stage2.src)
    );

    menu_pointer menu_pointer (
        .clk      (clk),
        .reset    (reset),
        .page     (page),
        .item     (item),
        .upstream (stage2.dst),
        .hsync    (hsync_out),
        .vsync    (vsync_out),
        .rgb      (rgb_out)
    );

endmodule

//--- bench/game_menu_assertions.sv
`include "menu_consts.svh"

module game_menu_assertions (
    input logic        clk,
    input logic        reset,
    input logic [10:0] hcount,
    input logic [10:0] vcount,
    input logic        hsync,
    input logic        vsync,
    input logic        hblnk,
    input logic        vblnk,
    input logic [2:0]  keyboard,
    input logic        back_to_main_menu_flag,
    input logic        hsync_out,
    input logic        vsync_out,
    input logic [11:0] rgb_out,
    input logic        start_game_flag
);

    int          error_count = 0;
    logic [1:0]  shadow_page;
    logic [1:0]  shadow_item;
    logic [1:0]  page_d1, page_d2, item_d1, item_d2;
    logic [10:0] hc_d1, hc_d2, hc_d3, vc_d1, vc_d2, vc_d3;
    logic        hb_d1, hb_d2, hb_d3, vb_d1, vb_d2, vb_d3;
    logic [1:0]  warm;
    logic        warm_ok, active3, bar3, ptr3;
    logic [11:0] grad3;

    function automatic logic over_bar(input logic [10:0] x, input logic [10:0] y,
                                      input logic [1:0] pg);
        int  bars;
        int  top;
        logic hit;
        bars = (pg == `MENU_PAGE_MAIN) ? 3 : ((pg == `MENU_PAGE_PLAYING) ? 0 : 1);
        hit  = 1'b0;
        for (int i = 0; i < bars; i++) begin
            top = `MENU_BAR_Y0 + `MENU_BAR_PITCH * i;
            if (x >= `MENU_BAR_X && x < `MENU_BAR_X + `MENU_BAR_W &&
                y >= top && y < top + `MENU_BAR_H)
                hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic over_pointer(input logic [10:0] x, input logic [10:0] y,
                                          input logic [1:0] pg, input logic [1:0] it);
        int top;
        top = `MENU_BAR_Y0 + `MENU_BAR_PITCH * int'(it);
        return pg != `MENU_PAGE_PLAYING &&
               x >= `MENU_PTR_X && x < `MENU_PTR_X + `MENU_PTR_SIZE &&
               y >= top && y < top + `MENU_PTR_SIZE;
    endfunction

    // Menu rule as seen from the top-level inputs.
    always_ff @(posedge clk) begin
        if (reset) begin
            shadow_page <= `MENU_PAGE_MAIN;
            shadow_item <= 2'd0;
        end else if (shadow_page == `MENU_PAGE_PLAYING) begin
            if (back_to_main_menu_flag) begin
                shadow_page <= `MENU_PAGE_MAIN;
                shadow_item <= 2'd0;
            end
        end else if (shadow_page != `MENU_PAGE_MAIN) begin
            shadow_item <= 2'd0;
            if (keyboard[`MENU_KEY_ENTER])
                shadow_page <= `MENU_PAGE_MAIN;
        end else if (keyboard[`MENU_KEY_ENTER]) begin
            shadow_item <= 2'd0;
            if (shadow_item == 2'd0)
                shadow_page <= `MENU_PAGE_PLAYING;
            else if (shadow_item == 2'd1)
                shadow_page <= `MENU_PAGE_OPTIONS;
            else
                shadow_page <= `MENU_PAGE_CREDITS;
        end else if (keyboard[`MENU_KEY_UP] && shadow_item > 2'd0) begin
            shadow_item <= shadow_item - 2'd1;
        end else if (keyboard[`MENU_KEY_DOWN] && shadow_item < 2'd2) begin
            shadow_item <= shadow_item + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            warm <= 2'd0;
        else if (warm != 2'd3)
            warm <= warm + 2'd1; // Pipeline holds real data after 3 clocks.
    end

    always_ff @(posedge clk) begin
        page_d1 <= shadow_page;
        page_d2 <= page_d1;
        item_d1 <= shadow_item;
        item_d2 <= item_d1;
        hc_d1   <= hcount;
        hc_d2   <= hc_d1;
        hc_d3   <= hc_d2;
        vc_d1   <= vcount;
        vc_d2   <= vc_d1;
        vc_d3   <= vc_d2;
        hb_d1   <= hblnk;
        hb_d2   <= hb_d1;
        hb_d3   <= hb_d2;
        vb_d1   <= vblnk;
        vb_d2   <= vb_d1;
        vb_d3   <= vb_d2;
    end

    assign warm_ok = (warm == 2'd3);
    assign active3 = !hb_d3 && !vb_d3;
    assign bar3    = over_bar(hc_d3, vc_d3, page_d2); // Menu state is 2 clocks old here.
    assign ptr3    = over_pointer(hc_d3, vc_d3, page_d2, item_d2);
    assign grad3   = {hc_d3[9:6], vc_d3[9:6], `MENU_BG_BLUE};

    sync_delay: assert property (@(posedge clk) disable iff (reset)
        warm_ok |-> (hsync_out == $past(hsync, 3) && vsync_out == $past(vsync, 3)))
        else begin
            error_count++;
            $error("mismatch at %0t: syncs do not trail the inputs by 3 clocks", $time);
        end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        warm_ok && !active3 |-> rgb_out == 12'h000)
        else begin
            error_count++;
            $error("mismatch at %0t: rgb_out %h during blanking", $time, rgb_out);
        end

    gradient: assert property (@(posedge clk) disable iff (reset)
        warm_ok && active3 && !bar3 && !ptr3 |-> rgb_out == grad3)
        else begin
            error_count++;
            $error("mismatch at %0t: background %h, expected %h", $time, rgb_out, grad3);
        end

    label_bar: assert property (@(posedge clk) disable iff (reset)
        warm_ok && active3 && bar3 |-> rgb_out == `MENU_BAR_RGB)
        else begin
            error_count++;
            $error("mismatch at %0t: bar pixel is %h", $time, rgb_out);
        end

    pointer: assert property (@(posedge clk) disable iff (reset)
        warm_ok && active3 && ptr3 |-> rgb_out == `MENU_PTR_RGB)
        else begin
            error_count++;
            $error("mismatch at %0t: pointer pixel is %h", $time, rgb_out);
        end

    flag_level: assert property (@(posedge clk) disable iff (reset)
        warm_ok |-> start_game_flag == (page_d1 == `MENU_PAGE_PLAYING))
        else begin
            error_count++;
            $error("mismatch at %0t: start_game_flag is %b", $time, start_game_flag);
        end

    flag_rise: assert property (@(posedge clk) disable iff (reset)
        shadow_page == `MENU_PAGE_MAIN && shadow_item == 2'd0 && keyboard[`MENU_KEY_ENTER]
        |-> ##2 $rose(start_game_flag))
        else begin
            error_count++;
            $error("mismatch at %0t: start_game_flag did not rise after enter", $time);
        end

    flag_fall: assert property (@(posedge clk) disable iff (reset)
        shadow_page == `MENU_PAGE_PLAYING && back_to_main_menu_flag
        |-> ##2 $fell(start_game_flag))
        else begin
            error_count++;
            $error("mismatch at %0t: start_game_flag did not fall on return", $time);
        end

endmodule

//--- bench/game_menu_tb.sv
`include "menu_consts.svh"

module game_menu_tb;

    // SVGA 800x600 at 60 Hz, positive syncs.
    localparam int H_TOTAL      = 1056;
    localparam int H_ACTIVE     = 800;
    localparam int H_SYNC_START = 840;
    localparam int H_SYNC_END   = 968;
    localparam int V_TOTAL      = 628;
    localparam int V_ACTIVE     = 600;
    localparam int V_SYNC_START = 601;
    localparam int V_SYNC_END   = 605;
    localparam int FRAMES       = 4;
    localparam int CYCLE_LIMIT  = FRAMES * H_TOTAL * V_TOTAL + 1000;
    localparam int KEY_GAP      = 8;
    localparam int DRIVE_DELAY  = 5;

    localparam logic [2:0] KEY_UP    = 3'(1 << `MENU_KEY_UP);
    localparam logic [2:0] KEY_DOWN  = 3'(1 << `MENU_KEY_DOWN);
    localparam logic [2:0] KEY_ENTER = 3'(1 << `MENU_KEY_ENTER);

    logic        clk;
    logic        reset;
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [2:0]  keyboard;
    logic        back_to_main_menu_flag;
    logic        hsync_out;
    logic        vsync_out;
    logic [11:0] rgb_out;
    logic        start_game_flag;
    int          cycles = 0;

    game_menu i_game_menu (
        .clk                    (clk),
        .reset                  (reset),
        .hcount                 (hcount),
        .vcount                 (vcount),
        .hsync                  (hsync),
        .vsync                  (vsync),
        .hblnk                  (hblnk),
        .vblnk                  (vblnk),
        .keyboard               (keyboard),
        .back_to_main_menu_flag (back_to_main_menu_flag),
        .hsync_out              (hsync_out),
        .vsync_out              (vsync_out),
        .rgb_out                (rgb_out),
        .start_game_flag        (start_game_flag)
    );

    bind game_menu game_menu_assertions menu_checks (
        .clk                    (clk),
        .reset                  (reset),
        .hcount                 (hcount),
        .vcount                 (vcount),
        .hsync                  (hsync),
        .vsync                  (vsync),
        .hblnk                  (hblnk),
        .vblnk                  (vblnk),
        .keyboard               (keyboard),
        .back_to_main_menu_flag (back_to_main_menu_flag),
        .hsync_out              (hsync_out),
        .vsync_out              (vsync_out),
        .rgb_out                (rgb_out),
        .start_game_flag        (start_game_flag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic set_timing(input int h, input int v);
        hcount = 11'(h);
        vcount = 11'(v);
        hsync  = (h >= H_SYNC_START && h < H_SYNC_END);
        vsync  = (v >= V_SYNC_START && v < V_SYNC_END);
        hblnk  = (h >= H_ACTIVE);
        vblnk  = (v >= V_ACTIVE);
    endtask

    // Each position is held for one clock, changing just after the edge.
    task automatic run_frames(input int count);
        for (int f = 0; f < count; f++) begin
            for (int v = 0; v < V_TOTAL; v++) begin
                for (int h = 0; h < H_TOTAL; h++) begin
                    set_timing(h, v);
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
        end
    endtask

    task automatic press_key(input logic [2:0] keys);
        @(posedge clk);
        #DRIVE_DELAY;
        keyboard = keys;
        @(posedge clk);
        #DRIVE_DELAY;
        keyboard = 3'b000;
        repeat (KEY_GAP - 2) @(posedge clk);
    endtask

    task automatic return_to_menu();
        @(posedge clk);
        #DRIVE_DELAY;
        back_to_main_menu_flag = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        back_to_main_menu_flag = 1'b0;
    endtask

    task automatic wait_for_vblank_start();
        do
            @(posedge clk);
        while (!(vcount == V_ACTIVE && hcount == 0));
    endtask

    // One group per vertical blank, so each frame shows a different page.
    task automatic play_group(input int group);
        case (group)
            0: begin
                press_key(KEY_DOWN);
                press_key(KEY_DOWN);
                press_key(KEY_DOWN); // Already on the last item.
            end
            1: begin
                press_key(KEY_UP);
                press_key(KEY_ENTER);
                press_key(KEY_ENTER);
                press_key(KEY_DOWN);
                press_key(KEY_DOWN);
                press_key(KEY_ENTER);
            end
            2: begin
                press_key(KEY_ENTER);
                press_key(KEY_UP); // Already on the first item.
                press_key(KEY_ENTER);
            end
            default: return_to_menu();
        endcase
    endtask

    task automatic run_script();
        for (int group = 0; group < FRAMES; group++) begin
            wait_for_vblank_start();
            repeat (KEY_GAP) @(posedge clk);
            play_group(group);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_game_menu.menu_checks.error_count != 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "a check failed at %0t", $time);
        end else if (cycles >= CYCLE_LIMIT) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout: the run exceeded its limit of %0d cycles", CYCLE_LIMIT);
        end
    end

    initial begin
        reset                  = 1'b1;
        keyboard               = 3'b000;
        back_to_main_menu_flag = 1'b0;
        set_timing(0, 0);
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        fork
            run_frames(FRAMES);
            run_script();
        join
        repeat (8) @(posedge clk); // Let the last pixels leave the pipeline.
        if (i_game_menu.menu_checks.error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "%0d checks failed", i_game_menu.menu_checks.error_count);
        end
    end

endmodule

//--- filelist.f
+incdir+include
verilog/menu_pkg.sv
verilog/vga_stream_if.sv
verilog/menu_background.sv
verilog/menu_page_fsm.sv
verilog/menu_labels.sv
verilog/menu_pointer.sv
verilog/game_menu.sv
bench/game_menu_assertions.sv
bench/game_menu_tb.sv
